// File: logic/pixel_pkg.sv
// Pixel formats and Q7 fixed-point constants
// Types for the frame statistics

package pixel_pkg;

    // ====================
    // Fixed-point format
    // ====================
    localparam int DATA_WIDTH = 16;
    localparam int FRAC_BITS  = 7;
    localparam int SUM_WIDTH  = 32;

    // Value of 1.0 in Q7
    localparam int Q7_ONE = 1 << FRAC_BITS;

    // Number of grey levels in a raw pixel byte
    localparam int PIXEL_LEVELS = 256;

    // ====================
    // Types
    // ====================
    typedef logic [7:0]                   pixel_byte_t;
    typedef logic signed [DATA_WIDTH-1:0] q7_pixel_t;
    typedef logic signed [SUM_WIDTH-1:0]  stat_sum_t;

    // Start values for the running minimum and maximum
    localparam q7_pixel_t Q7_MAX_POS = {1'b0, {(DATA_WIDTH-1){1'b1}}};
    localparam q7_pixel_t Q7_MIN_NEG = {1'b1, {(DATA_WIDTH-1){1'b0}}};

endpackage

// File: logic/link_pkg.sv
// Serial link types, report packet constants
// State encodings for the UART and the reporter FSMs

package link_pkg;

    localparam int UART_DATA_BITS = 8;

    typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

    // ====================
    // Report packet
    // ====================
    // 'I', sum (4 bytes, MSB first), min (2), max (2), newline
    localparam uart_byte_t MARK_STATS   = 8'h49;
    localparam uart_byte_t MARK_EOL     = 8'h0A;
    localparam int         REPORT_BYTES = 10;

    // ====================
    // FSM encodings
    // ====================
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

    typedef enum logic [1:0] {
        REP_IDLE,
        REP_READ,
        REP_SEND,
        REP_WAIT
    } report_state_t;

endpackage

// File: logic/uart_rx.sv
// UART receiver, 8N1, one-cycle valid pulse per byte
// Each bit is sampled at the middle of its period
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rx_i,
    output logic                 rx_valid_o,
    output link_pkg::uart_byte_t rx_byte_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(link_pkg::UART_DATA_BITS);

    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [BIT_W-1:0] bit_idx_t;

    localparam cnt_t     HALF_END = cnt_t'(CLKS_PER_BIT / 2 - 1);
    localparam cnt_t     BIT_END  = cnt_t'(CLKS_PER_BIT - 1);
    localparam bit_idx_t LAST_BIT = bit_idx_t'(link_pkg::UART_DATA_BITS - 1);

    link_pkg::uart_state_t state;
    cnt_t                  clk_cnt;
    bit_idx_t              bit_idx;
    logic                  rx_meta;
    logic                  rx_sync;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= link_pkg::UART_IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            case (state)
                link_pkg::UART_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= link_pkg::UART_START;
                    end
                end
                link_pkg::UART_START: begin
                    // Recheck the line at mid start bit, a glitch returns to idle
                    if (clk_cnt == HALF_END) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? link_pkg::UART_IDLE : link_pkg::UART_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                link_pkg::UART_DATA: begin
                    if (clk_cnt == BIT_END) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            state <= link_pkg::UART_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                link_pkg::UART_STOP: begin
                    if (clk_cnt == BIT_END) begin
                        rx_valid_o <= 1'b1;
                        state      <= link_pkg::UART_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Data arrives LSB first
    always_ff @(posedge clk) begin
        if (state == link_pkg::UART_DATA && clk_cnt == BIT_END) begin
            rx_byte_o <= {rx_sync, rx_byte_o[link_pkg::UART_DATA_BITS-1:1]};
        end
    end

endmodule

// File: logic/uart_tx.sv
// UART transmitter, 8N1, LSB first
// Busy covers the whole frame from start bit to end of stop bit
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tx_valid_i,
    input  link_pkg::uart_byte_t tx_byte_i,
    output logic                 tx_o,
    output logic                 tx_busy_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(link_pkg::UART_DATA_BITS);

    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [BIT_W-1:0] bit_idx_t;

    localparam cnt_t     BIT_END  = cnt_t'(CLKS_PER_BIT - 1);
    localparam bit_idx_t LAST_BIT = bit_idx_t'(link_pkg::UART_DATA_BITS - 1);

    link_pkg::uart_state_t state;
    cnt_t                  clk_cnt;
    bit_idx_t              bit_idx;
    link_pkg::uart_byte_t  shift_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= link_pkg::UART_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            tx_o      <= 1'b1;
            tx_busy_o <= 1'b0;
        end else begin
            case (state)
                link_pkg::UART_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (tx_valid_i) begin
                        tx_o      <= 1'b0;
                        tx_busy_o <= 1'b1;
                        state     <= link_pkg::UART_START;
                    end
                end
                link_pkg::UART_START: begin
                    if (clk_cnt == BIT_END) begin
                        clk_cnt <= '0;
                        tx_o    <= shift_q[0];
                        state   <= link_pkg::UART_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                link_pkg::UART_DATA: begin
                    if (clk_cnt == BIT_END) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            tx_o  <= 1'b1;
                            state <= link_pkg::UART_STOP;
                        end else begin
                            tx_o <= shift_q[1];
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                link_pkg::UART_STOP: begin
                    if (clk_cnt == BIT_END) begin
                        tx_busy_o <= 1'b0;
                        state     <= link_pkg::UART_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Byte latched on accept, shifted right after each data bit
    always_ff @(posedge clk) begin
        if (state == link_pkg::UART_IDLE && tx_valid_i) begin
            shift_q <= tx_byte_i;
        end else if (state == link_pkg::UART_DATA && clk_cnt == BIT_END) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// File: logic/pixel_loader.sv
// Pixel loader: UART bytes scaled to Q7 and written in raster order
// Wishbone classic master on the frame buffer write port
`timescale 1ns/1ps

module pixel_loader #(
    parameter  int IMG_SIZE     = 4,
    parameter  int CLKS_PER_BIT = 8,
    localparam int FRAME_DEPTH  = IMG_SIZE * IMG_SIZE,
    localparam int ADDR_W       = $clog2(FRAME_DEPTH)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  uart_rx_i,
    output logic                  wr_cyc_o,
    output logic                  wr_stb_o,
    output logic [ADDR_W-1:0]     wr_adr_o,
    output pixel_pkg::q7_pixel_t  wr_dat_o,
    input  logic                  wr_ack_i,
    output logic                  frame_loaded_o
);

    localparam int                LUT_DIV   = pixel_pkg::PIXEL_LEVELS - 1;
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FRAME_DEPTH - 1);

    logic                  rx_valid;
    link_pkg::uart_byte_t  rx_byte;
    logic                  wr_req;
    pixel_pkg::q7_pixel_t  q7_lut [pixel_pkg::PIXEL_LEVELS];

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx (
        .clk       (clk),
        .reset     (reset),
        .rx_i      (uart_rx_i),
        .rx_valid_o(rx_valid),
        .rx_byte_o (rx_byte)
    );

    // Grey level k maps to round(k * 128 / 255), so 255 gives exactly 1.0
    initial begin : build_lut
        int v;
        for (int k = 0; k < pixel_pkg::PIXEL_LEVELS; k++) begin
            v = (k * pixel_pkg::Q7_ONE + LUT_DIV / 2) / LUT_DIV;
            q7_lut[k] = pixel_pkg::q7_pixel_t'(v);
        end
    end

    // ====================
    // Write cycle control
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_req         <= 1'b0;
            wr_adr_o       <= '0;
            frame_loaded_o <= 1'b0;
        end else begin
            frame_loaded_o <= 1'b0;
            if (wr_req && wr_ack_i) begin
                wr_req <= 1'b0;
                if (wr_adr_o == LAST_ADDR) begin
                    wr_adr_o       <= '0;
                    frame_loaded_o <= 1'b1;
                end else begin
                    wr_adr_o <= wr_adr_o + 1'b1;
                end
            end else if (rx_valid) begin
                wr_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            wr_dat_o <= q7_lut[pixel_pkg::pixel_byte_t'(rx_byte)];
        end
    end

    assign wr_cyc_o = wr_req;
    assign wr_stb_o = wr_req;

    // A write finishes long before the next byte can arrive
    a_no_byte_while_pending: assert property (
        @(posedge clk) disable iff (reset) rx_valid |-> !wr_stb_o
    );

    a_ack_only_with_stb: assert property (
        @(posedge clk) disable iff (reset) wr_ack_i |-> wr_stb_o
    );

endmodule

// File: logic/frame_buffer.sv
// Frame memory of Q7 pixels
// Separate Wishbone classic write and read ports, registered ack
`timescale 1ns/1ps

module frame_buffer #(
    parameter  int IMG_SIZE    = 4,
    localparam int FRAME_DEPTH = IMG_SIZE * IMG_SIZE,
    localparam int ADDR_W      = $clog2(FRAME_DEPTH)
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_cyc_i,
    input  logic                 wr_stb_i,
    input  logic [ADDR_W-1:0]    wr_adr_i,
    input  pixel_pkg::q7_pixel_t wr_dat_i,
    output logic                 wr_ack_o,
    input  logic                 rd_cyc_i,
    input  logic                 rd_stb_i,
    input  logic [ADDR_W-1:0]    rd_adr_i,
    output pixel_pkg::q7_pixel_t rd_dat_o,
    output logic                 rd_ack_o
);

    pixel_pkg::q7_pixel_t mem [FRAME_DEPTH];

    logic wr_take;
    logic rd_take;

    // One access per strobe, the ack cycle itself is not taken again
    assign wr_take = wr_cyc_i && wr_stb_i && !wr_ack_o;
    assign rd_take = rd_cyc_i && rd_stb_i && !rd_ack_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ack_o <= 1'b0;
            rd_ack_o <= 1'b0;
        end else begin
            wr_ack_o <= wr_take;
            rd_ack_o <= rd_take;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            mem[wr_adr_i] <= wr_dat_i;
        end
        // Read data lines up with the ack cycle
        if (rd_take) begin
            rd_dat_o <= mem[rd_adr_i];
        end
    end

    // Single-cycle ack, and the master has let go of stb by then
    a_wr_ack_single: assert property (
        @(posedge clk) disable iff (reset) wr_ack_o |=> !wr_ack_o && !wr_stb_i
    );

    a_rd_ack_single: assert property (
        @(posedge clk) disable iff (reset) rd_ack_o |=> !rd_ack_o && !rd_stb_i
    );

endmodule

// File: logic/frame_reporter.sv
// Frame reporter: reads back the stored frame and keeps sum, min, max
// Sends the 10-byte statistics packet over the UART transmitter
`timescale 1ns/1ps

module frame_reporter #(
    parameter  int IMG_SIZE     = 4,
    parameter  int CLKS_PER_BIT = 8,
    localparam int FRAME_DEPTH  = IMG_SIZE * IMG_SIZE,
    localparam int ADDR_W       = $clog2(FRAME_DEPTH)
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frame_loaded_i,
    output logic                 rd_cyc_o,
    output logic                 rd_stb_o,
    output logic [ADDR_W-1:0]    rd_adr_o,
    input  pixel_pkg::q7_pixel_t rd_dat_i,
    input  logic                 rd_ack_i,
    output logic                 uart_tx_o
);

    localparam int IDX_W = $clog2(link_pkg::REPORT_BYTES);

    typedef logic [IDX_W-1:0] idx_t;

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(FRAME_DEPTH - 1);
    localparam idx_t              LAST_IDX  = idx_t'(link_pkg::REPORT_BYTES - 1);

    link_pkg::report_state_t state;
    logic                    rd_req;
    idx_t                    byte_idx;
    pixel_pkg::stat_sum_t    sum_q;
    pixel_pkg::q7_pixel_t    min_q;
    pixel_pkg::q7_pixel_t    max_q;
    logic                    tx_valid;
    link_pkg::uart_byte_t    tx_byte;
    logic                    tx_busy;

    // ====================
    // Read-back and send FSM
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= link_pkg::REP_IDLE;
            rd_req   <= 1'b0;
            rd_adr_o <= '0;
            byte_idx <= '0;
        end else begin
            case (state)
                link_pkg::REP_IDLE: begin
                    if (frame_loaded_i) begin
                        rd_req   <= 1'b1;
                        rd_adr_o <= '0;
                        state    <= link_pkg::REP_READ;
                    end
                end
                link_pkg::REP_READ: begin
                    // stb drops for a cycle after every ack
                    if (!rd_req) begin
                        rd_req <= 1'b1;
                    end else if (rd_ack_i) begin
                        rd_req <= 1'b0;
                        if (rd_adr_o == LAST_ADDR) begin
                            byte_idx <= '0;
                            state    <= link_pkg::REP_SEND;
                        end else begin
                            rd_adr_o <= rd_adr_o + 1'b1;
                        end
                    end
                end
                link_pkg::REP_SEND: begin
                    state <= link_pkg::REP_WAIT;
                end
                link_pkg::REP_WAIT: begin
                    if (!tx_busy) begin
                        if (byte_idx == LAST_IDX) begin
                            state <= link_pkg::REP_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= link_pkg::REP_SEND;
                        end
                    end
                end
            endcase
        end
    end

    // Statistics, signed compare on Q7 values
    always_ff @(posedge clk) begin
        if (reset || (state == link_pkg::REP_IDLE && frame_loaded_i)) begin
            sum_q <= '0;
            min_q <= pixel_pkg::Q7_MAX_POS;
            max_q <= pixel_pkg::Q7_MIN_NEG;
        end else if (state == link_pkg::REP_READ && rd_req && rd_ack_i) begin
            sum_q <= sum_q + pixel_pkg::stat_sum_t'(rd_dat_i);
            if (rd_dat_i < min_q) begin
                min_q <= rd_dat_i;
            end
            if (rd_dat_i > max_q) begin
                max_q <= rd_dat_i;
            end
        end
    end

    assign rd_cyc_o = rd_req;
    assign rd_stb_o = rd_req;

    // Packet byte select, multi-byte fields MSB first
    always_comb begin
        case (byte_idx)
            idx_t'(0): tx_byte = link_pkg::MARK_STATS;
            idx_t'(1): tx_byte = sum_q[31:24];
            idx_t'(2): tx_byte = sum_q[23:16];
            idx_t'(3): tx_byte = sum_q[15:8];
            idx_t'(4): tx_byte = sum_q[7:0];
            idx_t'(5): tx_byte = min_q[15:8];
            idx_t'(6): tx_byte = min_q[7:0];
            idx_t'(7): tx_byte = max_q[15:8];
            idx_t'(8): tx_byte = max_q[7:0];
            default:   tx_byte = link_pkg::MARK_EOL;
        endcase
    end

    assign tx_valid = (state == link_pkg::REP_SEND);

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_tx (
        .clk       (clk),
        .reset     (reset),
        .tx_valid_i(tx_valid),
        .tx_byte_i (tx_byte),
        .tx_o      (uart_tx_o),
        .tx_busy_o (tx_busy)
    );

    // A new frame must not complete while a report is still running
    a_loaded_in_idle: assert property (
        @(posedge clk) disable iff (reset) frame_loaded_i |-> state == link_pkg::REP_IDLE
    );

endmodule

// File: logic/frame_stats_top.sv
// Top level: pixel loader, frame buffer and statistics reporter
`timescale 1ns/1ps

module frame_stats_top #(
    parameter int IMG_SIZE     = 4,
    parameter int CLKS_PER_BIT = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic uart_rx_i,
    output logic uart_tx_o,
    output logic frame_loaded_o
);

    localparam int FRAME_DEPTH = IMG_SIZE * IMG_SIZE;
    localparam int ADDR_W      = $clog2(FRAME_DEPTH);

    // Write link, loader to buffer
    logic                 wr_cyc;
    logic                 wr_stb;
    logic [ADDR_W-1:0]    wr_adr;
    pixel_pkg::q7_pixel_t wr_dat;
    logic                 wr_ack;

    // Read link, reporter to buffer
    logic                 rd_cyc;
    logic                 rd_stb;
    logic [ADDR_W-1:0]    rd_adr;
    pixel_pkg::q7_pixel_t rd_dat;
    logic                 rd_ack;

    pixel_loader #(
        .IMG_SIZE    (IMG_SIZE),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_pixel_loader (
        .clk           (clk),
        .reset         (reset),
        .uart_rx_i     (uart_rx_i),
        .wr_cyc_o      (wr_cyc),
        .wr_stb_o      (wr_stb),
        .wr_adr_o      (wr_adr),
        .wr_dat_o      (wr_dat),
        .wr_ack_i      (wr_ack),
        .frame_loaded_o(frame_loaded_o)
    );

    frame_buffer #(
        .IMG_SIZE(IMG_SIZE)
    ) u_frame_buffer (
        .clk     (clk),
        .reset   (reset),
        .wr_cyc_i(wr_cyc),
        .wr_stb_i(wr_stb),
        .wr_adr_i(wr_adr),
        .wr_dat_i(wr_dat),
        .wr_ack_o(wr_ack),
        .rd_cyc_i(rd_cyc),
        .rd_stb_i(rd_stb),
        .rd_adr_i(rd_adr),
        .rd_dat_o(rd_dat),
        .rd_ack_o(rd_ack)
    );

    frame_reporter #(
        .IMG_SIZE    (IMG_SIZE),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_frame_reporter (
        .clk           (clk),
        .reset         (reset),
        .frame_loaded_i(frame_loaded_o),
        .rd_cyc_o      (rd_cyc),
        .rd_stb_o      (rd_stb),
        .rd_adr_o      (rd_adr),
        .rd_dat_i      (rd_dat),
        .rd_ack_i      (rd_ack),
        .uart_tx_o     (uart_tx_o)
    );

endmodule

// File: dv/tb_clock.sv
// Free-running testbench clock, 4 ns period
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 2
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

// File: dv/frame_stats_tb.sv
// Testbench for frame_stats_top
// UART frame driver, report packet decoder and a table of frames with expected statistics
`timescale 1ns/1ps

module frame_stats_tb;

    localparam int IMG_SIZE       = 4;
    localparam int CLKS_PER_BIT   = 8;
    localparam int FRAME_PIXELS   = IMG_SIZE * IMG_SIZE;
    localparam int PACKET_BYTES   = 10;
    localparam int N_TESTS        = 5;
    localparam int TIMEOUT_CYCLES =
        N_TESTS * (FRAME_PIXELS + PACKET_BYTES) * 10 * CLKS_PER_BIT + 1000;

    logic clk;
    logic reset;
    logic rx_line;
    logic tx_line;
    logic frame_loaded;

    // ====================
    // Test table
    // ====================
    string      test_name [N_TESTS];
    logic [7:0] pixels    [N_TESTS][FRAME_PIXELS];
    int         exp_sum   [N_TESTS];
    int         exp_min   [N_TESTS];
    int         exp_max   [N_TESTS];

    logic [7:0] packet [PACKET_BYTES];
    int         errors;
    int         checks;
    int         monitor_errors = 0;
    int         loaded_count   = 0;
    int         cycle_count    = 0;
    logic       idle_watch     = 1'b0;

    tb_clock u_tb_clock (
        .clk(clk)
    );

    frame_stats_top #(
        .IMG_SIZE    (IMG_SIZE),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_frame_stats_top (
        .clk           (clk),
        .reset         (reset),
        .uart_rx_i     (rx_line),
        .uart_tx_o     (tx_line),
        .frame_loaded_o(frame_loaded)
    );

    // Grey level to Q7, rounded k * 128 / 255
    function automatic int q7_value(input logic [7:0] k);
        return (int'(k) * 128 + 127) / 255;
    endfunction

    task automatic build_table();
        int q;
        test_name[0] = "all_zero";
        test_name[1] = "all_full";
        test_name[2] = "ramp";
        test_name[3] = "random_a";
        test_name[4] = "random_b";
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            pixels[0][i] = 8'd0;
            pixels[1][i] = 8'd255;
            pixels[2][i] = 8'(i * 17);
            pixels[3][i] = 8'($urandom % 256);
            pixels[4][i] = 8'($urandom % 256);
        end
        for (int t = 0; t < N_TESTS; t++) begin
            exp_sum[t] = 0;
            exp_min[t] = 32767;
            exp_max[t] = -32768;
            for (int i = 0; i < FRAME_PIXELS; i++) begin
                q = q7_value(pixels[t][i]);
                exp_sum[t] = exp_sum[t] + q;
                if (q < exp_min[t]) begin
                    exp_min[t] = q;
                end
                if (q > exp_max[t]) begin
                    exp_max[t] = q;
                end
            end
        end
    endtask

    // ====================
    // Serial line helpers
    // ====================
    // Called right after a rising edge
    task automatic drive_bit(input logic b);
        rx_line <= b;
        repeat (CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(1'b1);
    endtask

    // Mid-bit sampling on the falling edge
    task automatic receive_byte(output logic [7:0] b);
        while (tx_line !== 1'b0) begin
            @(negedge clk);
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        if (tx_line !== 1'b0) begin
            errors++;
            $display("Start bit on uart_tx_o did not stay low until mid-bit");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = tx_line;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (tx_line !== 1'b1) begin
            errors++;
            $display("Stop bit on uart_tx_o was not high");
        end
    endtask

    task automatic compare_field(input string name, input string field,
                                 input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("[ERROR] %s %s: expected %0d, actual %0d", name, field, expected, actual);
        end
    endtask

    // ====================
    // Monitors
    // ====================
    always @(negedge clk) begin
        if (frame_loaded === 1'b1) begin
            loaded_count++;
        end
        if (idle_watch && (tx_line !== 1'b1 || frame_loaded !== 1'b0)) begin
            monitor_errors++;
            $display("Output left idle before the first frame was complete");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: reports did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        logic [7:0] b;
        reset   = 1'b1;
        rx_line = 1'b1;
        errors  = 0;
        checks  = 0;
        void'($urandom(32'hb93eb076));
        build_table();

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        idle_watch = 1'b1;
        repeat (4) @(posedge clk);

        for (int t = 0; t < N_TESTS; t++) begin
            for (int i = 0; i < FRAME_PIXELS; i++) begin
                // Last byte of the first frame may end the idle period
                if (t == 0 && i == FRAME_PIXELS - 1) begin
                    idle_watch = 1'b0;
                end
                send_byte(pixels[t][i]);
            end
            for (int n = 0; n < PACKET_BYTES; n++) begin
                receive_byte(b);
                packet[n] = b;
            end
            compare_field(test_name[t], "marker", 32'h49, int'(packet[0]));
            compare_field(test_name[t], "sum", exp_sum[t],
                          int'($signed({packet[1], packet[2], packet[3], packet[4]})));
            compare_field(test_name[t], "min", exp_min[t],
                          int'($signed({packet[5], packet[6]})));
            compare_field(test_name[t], "max", exp_max[t],
                          int'($signed({packet[7], packet[8]})));
            compare_field(test_name[t], "newline", 32'h0A, int'(packet[9]));
            compare_field(test_name[t], "frame pulses", t + 1, loaded_count);
            @(posedge clk);
        end

        $display("Checks: %0d, errors: %0d", checks, errors + monitor_errors);
        if (errors + monitor_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/pixel_pkg.sv
logic/link_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/pixel_loader.sv
logic/frame_buffer.sv
logic/frame_reporter.sv
logic/frame_stats_top.sv
dv/tb_clock.sv
dv/frame_stats_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= frame_stats_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TB PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
